// File: fifo_stim.txt
# one command per line: op letter then a hex argument
# W word | R bytes | F expected words | S settle (arg unused) | E empty reads | M cycles
W 03020100
W 07060504
S 0
R 8
E 4
W a1b2c3d4
W 11223344
R 3
S 0
R 5
S 0
F 10
S 0
R 4
S 0
F 1
R 40
E 3
M 12c
S 0
E 2
S 0

// File: all.f
fifo_pkg.sv
gray_counter.sv
cdc_sync.sv
fifo_async.sv
fifo_dp_ram.sv
fifo_async_top.sv
tb_clock_gen.sv
tb_fifo_async.sv

// File: run.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_fifo_async -f all.f

./obj_dir/Vtb_fifo_async > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

// File: tb_fifo_async.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_async;

   import fifo_pkg::*;

   localparam int SEED     = 24937;
   localparam int MAX_CMDS = 64;
   localparam int NO_LIMIT = 1 << 30;

   logic    w_clk;
   logic    r_clk;
   logic    reset;
   logic    w_en;
   w_data_t w_data;
   logic    r_en;
   logic    w_empty;
   logic    w_full;
   level_t  w_level;
   r_data_t r_data;
   logic    r_empty;
   logic    r_full;
   level_t  r_level;

   // commands from the stimulus file
   logic [7:0]  cmd_op  [MAX_CMDS];
   logic [31:0] cmd_arg [MAX_CMDS];
   int          cmd_cnt;
   int          cur_cmd = -1;

   // byte queue model, lane 0 of each word first
   r_data_t model_q [$];
   r_data_t last_byte;

   int err_count;
   int tests_ok;
   int tests_bad;
   int cycle_count;
   int cycle_limit;
   bit stim_ok;

   tb_clock_gen #(.PERIOD_NS(100)) w_clk_gen_i (.clk_o(w_clk));
   tb_clock_gen #(.PERIOD_NS(130)) r_clk_gen_i (.clk_o(r_clk));

   fifo_async_top dut_i (
      .w_clk_i   (w_clk),
      .r_clk_i   (r_clk),
      .reset_i   (reset),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_empty_o (w_empty),
      .w_full_o  (w_full),
      .w_level_o (w_level),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .r_full_o  (r_full),
      .r_level_o (r_level)
   );

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERR time %0t: %s expected %0h, got %0h", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic load_stim(output bit ok);
      int          fd;
      string       line;
      logic [7:0]  op;
      logic [31:0] arg;
      ok = 1'b0;
      cmd_cnt = 0;
      fd = $fopen("fifo_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file fifo_stim.txt");
      end else begin
         while (!$feof(fd) && cmd_cnt < MAX_CMDS) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and comment lines carry no command
            if (line.len() > 1 && line.getc(0) != "#") begin
               if ($sscanf(line, "%c %h", op, arg) == 2) begin
                  cmd_op[cmd_cnt]  = op;
                  cmd_arg[cmd_cnt] = arg;
                  cmd_cnt++;
               end else begin
                  $display("stimulus line could not be parsed: %s", line);
                  err_count++;
               end
            end
         end
         $fclose(fd);
         ok = (cmd_cnt > 0);
      end
   endtask

   // rough length of a command in write clock cycles
   function automatic int cmd_length(input logic [7:0] op, input logic [31:0] arg);
      case (op)
         "W":     return 4;
         "S":     return 16;
         "E":     return 140 + 2 * int'(arg);
         default: return 2 * int'(arg) + 8;
      endcase
   endfunction

   // one attempt per write clock, acceptance decided by the flag before the edge
   task automatic run_writer(input int max_words, input int max_cycles, input bit rand_en,
                             input bit use_word, input w_data_t word, input bit stop_on_full,
                             output int accepted);
      int      cyc;
      bit      full_seen;
      w_data_t cur;
      accepted = 0;
      cyc = 0;
      full_seen = 1'b0;
      while (accepted < max_words && cyc < max_cycles && !(stop_on_full && full_seen)) begin
         @(posedge w_clk);
         cur = use_word ? word : w_data_t'($urandom);
         w_en   <= rand_en ? 1'($urandom % 2) : 1'b1;
         w_data <= cur;
         @(negedge w_clk);
         if (w_en && !w_full) begin
            for (int lane = 0; lane < 4; lane++) begin
               model_q.push_back(cur[lane*8 +: 8]);
            end
            accepted++;
         end
         full_seen = w_full;
         cyc++;
      end
      @(posedge w_clk);
      w_en <= 1'b0;
   endtask

   // a byte accepted at one edge is checked after the next edge
   task automatic run_reader(input int max_bytes, input int max_cycles, input bit rand_en);
      int      got;
      int      cyc;
      bit      pend;
      r_data_t exp_byte;
      got = 0;
      cyc = 0;
      pend = 1'b0;
      while (got < max_bytes && cyc < max_cycles) begin
         @(posedge r_clk);
         r_en <= rand_en ? 1'($urandom % 2) : 1'b1;
         @(negedge r_clk);
         if (pend) begin
            check_value("r_data_o", exp_byte, r_data);
            pend = 1'b0;
         end
         if (r_en && !r_empty) begin
            if (model_q.size() == 0) begin
               $display("read accepted at %0t while no byte had been written", $time);
               err_count++;
            end else begin
               exp_byte  = model_q.pop_front();
               last_byte = exp_byte;
               pend = 1'b1;
               got++;
            end
         end
         cyc++;
      end
      @(posedge r_clk);
      r_en <= 1'b0;
      if (pend) begin
         @(negedge r_clk);
         check_value("r_data_o", exp_byte, r_data);
      end
   endtask

   task automatic settle_and_check();
      int n;
      repeat (10) @(posedge r_clk);
      n = model_q.size();
      @(negedge w_clk);
      check_value("w_level_o", n, w_level);
      check_value("w_empty_o", n < 4, w_empty);
      check_value("w_full_o", n > 60, w_full);
      @(negedge r_clk);
      check_value("r_level_o", n, r_level);
      check_value("r_empty_o", n < 1, r_empty);
      check_value("r_full_o", n > 63, r_full);
   endtask

   task automatic fill_until_full(input int exp_words);
      int acc;
      int dropped;
      run_writer(64, NO_LIMIT, 1'b0, 1'b0, '0, 1'b1, acc);
      check_value("accepted words", exp_words, acc);
      // more writes while full must all be dropped
      run_writer(3, 3, 1'b0, 1'b0, '0, 1'b0, dropped);
      check_value("writes accepted while full", 0, dropped);
   endtask

   task automatic drain_and_read_empty(input int n);
      run_reader(model_q.size(), NO_LIMIT, 1'b0);
      repeat (n) begin
         @(posedge r_clk);
         r_en <= 1'b1;
         @(negedge r_clk);
         check_value("r_empty_o", 1, r_empty);
         check_value("r_data_o", last_byte, r_data);
      end
      @(posedge r_clk);
      r_en <= 1'b0;
      @(negedge r_clk);
      check_value("r_data_o", last_byte, r_data);
   endtask

   task automatic run_command(input int idx);
      int errs_before;
      int acc;
      errs_before = err_count;
      case (cmd_op[idx])
         "W": run_writer(1, NO_LIMIT, 1'b0, 1'b1, cmd_arg[idx], 1'b0, acc);
         "R": run_reader(cmd_arg[idx], NO_LIMIT, 1'b0);
         "F": fill_until_full(cmd_arg[idx]);
         "S": settle_and_check();
         "E": drain_and_read_empty(cmd_arg[idx]);
         "M": begin
            fork
               run_writer(NO_LIMIT, cmd_arg[idx], 1'b1, 1'b0, '0, 1'b0, acc);
               run_reader(NO_LIMIT, cmd_arg[idx], 1'b1);
            join
         end
         default: begin
            $display("unknown stimulus command %c", cmd_op[idx]);
            err_count++;
         end
      endcase
      if (err_count == errs_before) tests_ok++;
      else tests_bad++;
      $display("test %0d (%c %0h): %s", idx, cmd_op[idx], cmd_arg[idx],
               (err_count == errs_before) ? "ok" : "FAILED");
   endtask

   always @(posedge w_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d write clock cycles, command %0d stalled",
                  cycle_count, cur_cmd);
         $display("Verification failed");
         $finish;
      end
   end

   initial begin
      int total;
      reset  = 1'b1;
      w_en   = 1'b0;
      w_data = '0;
      r_en   = 1'b0;
      err_count = 0;
      tests_ok = 0;
      tests_bad = 0;
      cycle_count = 0;
      cycle_limit = 0;
      void'($urandom(SEED));
      load_stim(stim_ok);
      total = 0;
      for (int i = 0; i < cmd_cnt; i++) begin
         total += cmd_length(cmd_op[i], cmd_arg[i]);
      end
      cycle_limit = 2 * total + 200;
      repeat (8) @(posedge w_clk);
      reset <= 1'b0;
      // reset values as seen from both domains
      repeat (2) @(negedge w_clk);
      check_value("w_empty_o", 1, w_empty);
      check_value("w_full_o", 0, w_full);
      check_value("w_level_o", 0, w_level);
      @(negedge r_clk);
      check_value("r_empty_o", 1, r_empty);
      check_value("r_full_o", 0, r_full);
      check_value("r_level_o", 0, r_level);
      if (err_count == 0) tests_ok++;
      else tests_bad++;
      $display("test reset: %s", (err_count == 0) ? "ok" : "FAILED");
      for (int i = 0; i < cmd_cnt; i++) begin
         cur_cmd = i;
         run_command(i);
      end
      $display("tests ok: %0d, tests failed: %0d, check errors: %0d",
               tests_ok, tests_bad, err_count);
      if (!stim_ok || tests_bad != 0 || err_count != 0) begin
         $display("Verification failed");
      end else begin
         $display("Verification passed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   // free running, low for the first half period
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// File: fifo_async_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_async_top (
   input  wire                    w_clk_i,
   input  wire                    r_clk_i,
   input  wire                    reset_i,

   // write side
   input  wire                    w_en_i,
   input  wire fifo_pkg::w_data_t w_data_i,
   output logic                   w_empty_o,
   output logic                   w_full_o,
   output fifo_pkg::level_t       w_level_o,

   // read side
   input  wire                    r_en_i,
   output fifo_pkg::r_data_t      r_data_o,
   output logic                   r_empty_o,
   output logic                   r_full_o,
   output fifo_pkg::level_t       r_level_o
);

   import fifo_pkg::*;

   // core to RAM
   logic                mem_w_en;
   logic [W_ADDR_W-1:0] mem_w_addr;
   w_data_t             mem_w_data;
   logic                mem_r_en;
   logic [R_ADDR_W-1:0] mem_r_addr;

   fifo_async fifo_i (
      .w_clk_i      (w_clk_i),
      .r_clk_i      (r_clk_i),
      .reset_i      (reset_i),
      .w_en_i       (w_en_i),
      .w_data_i     (w_data_i),
      .w_empty_o    (w_empty_o),
      .w_full_o     (w_full_o),
      .w_level_o    (w_level_o),
      .r_en_i       (r_en_i),
      .r_empty_o    (r_empty_o),
      .r_full_o     (r_full_o),
      .r_level_o    (r_level_o),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr)
   );

   // each side of the RAM runs on its own FIFO clock
   fifo_dp_ram ram_i (
      .w_clk_i  (w_clk_i),
      .w_en_i   (mem_w_en),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_clk_i  (r_clk_i),
      .r_en_i   (mem_r_en),
      .r_addr_i (mem_r_addr),
      .r_data_o (r_data_o)
   );

endmodule

`default_nettype wire

// File: fifo_dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_dp_ram (
   // write port
   input  wire                            w_clk_i,
   input  wire                            w_en_i,
   input  wire [fifo_pkg::W_ADDR_W-1:0]   w_addr_i,
   input  wire fifo_pkg::w_data_t         w_data_i,

   // read port
   input  wire                            r_clk_i,
   input  wire                            r_en_i,
   input  wire [fifo_pkg::R_ADDR_W-1:0]   r_addr_i,
   output fifo_pkg::r_data_t              r_data_o
);

   import fifo_pkg::*;

   // 16 words of four byte lanes, 64 bytes total
   w_data_t mem [0:(1 << W_ADDR_W)-1];

   logic [W_ADDR_W-1:0]  r_word_addr;
   logic [RATIO_LOG-1:0] r_lane;
   w_data_t              r_word;

   // the whole word goes in at once, lane 0 is the low byte
   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   assign r_word_addr = r_addr_i[R_ADDR_W-1:RATIO_LOG];
   assign r_lane      = r_addr_i[RATIO_LOG-1:0];
   assign r_word      = mem[r_word_addr];

   // byte held until the next enabled read
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= r_word[r_lane*R_DATA_W +: R_DATA_W];
      end
   end

endmodule

`default_nettype wire

// File: fifo_async.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_async (
   input  wire                               w_clk_i,
   input  wire                               r_clk_i,
   input  wire                               reset_i,

   // write side
   input  wire                               w_en_i,
   input  wire fifo_pkg::w_data_t            w_data_i,
   output logic                              w_empty_o,
   output logic                              w_full_o,
   output fifo_pkg::level_t                  w_level_o,

   // read side
   input  wire                               r_en_i,
   output logic                              r_empty_o,
   output logic                              r_full_o,
   output fifo_pkg::level_t                  r_level_o,

   // memory write port
   output logic                              mem_w_en_o,
   output logic [fifo_pkg::W_ADDR_W-1:0]     mem_w_addr_o,
   output fifo_pkg::w_data_t                 mem_w_data_o,

   // memory read port
   output logic                              mem_r_en_o,
   output logic [fifo_pkg::R_ADDR_W-1:0]     mem_r_addr_o
);

   import fifo_pkg::*;

   // accepted operations
   logic w_en_int;
   logic r_en_int;

   // gray pointers, local and synchronized copies
   w_ptr_t w_wptr_gray;
   w_ptr_t r_wptr_gray;
   r_ptr_t r_rptr_gray;
   r_ptr_t w_rptr_gray;

   // binary pointers in byte units, ADDR_W+1 bits wide
   logic [ADDR_W:0] w_wptr_bin;
   logic [ADDR_W:0] r_wptr_bin;
   logic [ADDR_W:0] w_wptr_norm;
   logic [ADDR_W:0] r_wptr_norm;
   logic [ADDR_W:0] r_rptr_bin;
   logic [ADDR_W:0] w_rptr_bin;

   // a write needs room for a full word, a read needs one byte
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   gray_counter #(
      .WIDTH(W_ADDR_W + 1)
   ) w_ptr_cnt_i (
      .clk_i   (w_clk_i),
      .reset_i (reset_i),
      .en_i    (w_en_int),
      .gray_o  (w_wptr_gray)
   );

   gray_counter #(
      .WIDTH(R_ADDR_W + 1)
   ) r_ptr_cnt_i (
      .clk_i   (r_clk_i),
      .reset_i (reset_i),
      .en_i    (r_en_int),
      .gray_o  (r_rptr_gray)
   );

   // write pointer into the read domain
   cdc_sync #(
      .WIDTH(W_ADDR_W + 1)
   ) w2r_sync_i (
      .clk_i    (r_clk_i),
      .reset_i  (reset_i),
      .signal_i (w_wptr_gray),
      .signal_o (r_wptr_gray)
   );

   // read pointer into the write domain
   cdc_sync #(
      .WIDTH(R_ADDR_W + 1)
   ) r2w_sync_i (
      .clk_i    (w_clk_i),
      .reset_i  (reset_i),
      .signal_i (r_rptr_gray),
      .signal_o (w_rptr_gray)
   );

   // word pointers are zero extended before conversion
   assign w_wptr_bin = gray_to_bin({{RATIO_LOG{1'b0}}, w_wptr_gray});
   assign r_wptr_bin = gray_to_bin({{RATIO_LOG{1'b0}}, r_wptr_gray});
   assign r_rptr_bin = gray_to_bin(r_rptr_gray);
   assign w_rptr_bin = gray_to_bin(w_rptr_gray);

   // word count times four gives byte units, wrap bit lands on the top bit
   assign w_wptr_norm = w_wptr_bin << RATIO_LOG;
   assign r_wptr_norm = r_wptr_bin << RATIO_LOG;

   // write domain level and flags
   assign w_level_o = w_wptr_norm - w_rptr_bin;
   assign w_empty_o = (w_level_o < W_INCR);
   assign w_full_o  = (w_level_o > (FIFO_BYTES - W_INCR));

   // read domain level and flags
   assign r_level_o = r_wptr_norm - r_rptr_bin;
   assign r_empty_o = (r_level_o < R_INCR);
   assign r_full_o  = (r_level_o > (FIFO_BYTES - R_INCR));

   // memory ports, wrap bit dropped from the addresses
   assign mem_w_en_o   = w_en_int;
   assign mem_w_addr_o = w_wptr_bin[W_ADDR_W-1:0];
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = r_en_int;
   assign mem_r_addr_o = r_rptr_bin[R_ADDR_W-1:0];

   no_write_when_full_a: assert property (
      @(posedge w_clk_i) disable iff (reset_i)
         mem_w_en_o |-> !w_full_o
   ) else $error("fifo_async: memory write while full");

   no_read_when_empty_a: assert property (
      @(posedge r_clk_i) disable iff (reset_i)
         mem_r_en_o |-> !r_empty_o
   ) else $error("fifo_async: memory read while empty");

   // the stale remote pointer must never push either level past capacity
   w_level_bound_a: assert property (
      @(posedge w_clk_i) disable iff (reset_i)
         w_level_o <= FIFO_BYTES
   ) else $error("fifo_async: write level %0d above capacity", w_level_o);

   r_level_bound_a: assert property (
      @(posedge r_clk_i) disable iff (reset_i)
         r_level_o <= FIFO_BYTES
   ) else $error("fifo_async: read level %0d above capacity", r_level_o);

endmodule

`default_nettype wire

// File: cdc_sync.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_sync #(
   parameter int WIDTH = 4
) (
   input  wire              clk_i,
   input  wire              reset_i,
   input  wire  [WIDTH-1:0] signal_i,
   output logic [WIDTH-1:0] signal_o
);

   // first stage may go metastable, second stage is what the domain uses
   logic [WIDTH-1:0] meta_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta_q   <= '0;
         signal_o <= '0;
      end else begin
         meta_q   <= signal_i;
         signal_o <= meta_q;
      end
   end

endmodule

`default_nettype wire

// File: gray_counter.sv
`timescale 1ns/1ps
`default_nettype none

module gray_counter #(
   parameter int WIDTH = 4
) (
   input  wire              clk_i,
   input  wire              reset_i,
   input  wire              en_i,
   output logic [WIDTH-1:0] gray_o
);

   logic [WIDTH-1:0] bin_q;
   logic [WIDTH-1:0] bin_next;

   assign bin_next = bin_q + 1'b1;

   // binary count kept alongside, gray value registered so it leaves glitch free
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bin_q  <= '0;
         gray_o <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         gray_o <= bin_next ^ (bin_next >> 1);
      end
   end

   // pointer crosses clock domains, so only one bit may flip per edge
   // first edge after reset compares against a pre-reset value, skip it
   gray_one_bit_step_a: assert property (
      @(posedge clk_i) disable iff (reset_i)
         !$past(reset_i) |-> ($countones(gray_o ^ $past(gray_o)) <= 1)
   ) else $error("gray_counter: more than one bit changed in one cycle");

endmodule

`default_nettype wire

// File: fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // word widths on the two sides
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // address space counted in bytes, the narrow side
   localparam int ADDR_W    = 6;
   localparam int RATIO_LOG = 2;
   localparam int W_ADDR_W  = ADDR_W - RATIO_LOG;
   localparam int R_ADDR_W  = ADDR_W;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;

   // pointers carry one extra wrap bit
   typedef logic [W_ADDR_W:0] w_ptr_t;
   typedef logic [R_ADDR_W:0] r_ptr_t;

   // level needs to reach FIFO_BYTES itself
   typedef logic [ADDR_W:0] level_t;

   localparam level_t FIFO_BYTES = level_t'(1 << ADDR_W);
   localparam level_t W_INCR     = level_t'(1 << RATIO_LOG);
   localparam level_t R_INCR     = level_t'(1);

   // converts a gray pointer of up to ADDR_W+1 bits
   // narrower pointers are passed zero extended, upper result bits stay zero
   function automatic logic [ADDR_W:0] gray_to_bin(input logic [ADDR_W:0] gray);
      logic [ADDR_W:0] bin;
      bin[ADDR_W] = gray[ADDR_W];
      for (int i = ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire
